/* hdl/cfg_extract_pkg.sv */
package cfg_extract_pkg;

    ////////////////////////////////////////
    // stream and table geometry
    ////////////////////////////////////////
    localparam int DATA_W    = 256;
    localparam int KEEP_W    = DATA_W / 8;      // one enable per byte
    localparam int ORDER_W   = 16;
    localparam int LANES     = DATA_W / ORDER_W; // orders per beat
    localparam int NUM_SEG   = 4;               // payload beats per config packet
    localparam int SEG_IDX_W = $clog2(NUM_SEG);
    localparam int CFG_W     = NUM_SEG * DATA_W;

    localparam logic [SEG_IDX_W-1:0] LAST_SEG = SEG_IDX_W'(NUM_SEG - 1);

    // header beat 2 id field
    localparam int MOD_ID_W   = 4;
    localparam int MOD_ID_LSB = 112;
    localparam logic [MOD_ID_W-1:0] CFG_MODULE_ID = 4'd15;

    ////////////////////////////////////////
    // rx fsm state codes
    ////////////////////////////////////////
    localparam int STATE_W = 3;

    localparam logic [STATE_W-1:0] ST_HDR1     = 3'd0; // waiting for header beat 1
    localparam logic [STATE_W-1:0] ST_HDR2     = 3'd1; // header beat 2 carries the id
    localparam logic [STATE_W-1:0] ST_LOAD     = 3'd2;
    localparam logic [STATE_W-1:0] ST_FWD      = 3'd3;
    localparam logic [STATE_W-1:0] ST_FWD_TAIL = 3'd4; // last foreign beat still in stage 1
    localparam logic [STATE_W-1:0] ST_FLUSH    = 3'd5;

    // one beat, read as a header by the fsm and as payload lanes by the table store
    typedef union packed {
        struct packed {
            logic [DATA_W-MOD_ID_LSB-MOD_ID_W-1:0] rsvd_hi;
            logic [MOD_ID_W-1:0]                   mod_id;
            logic [MOD_ID_LSB-1:0]                 rsvd_lo;
        } hdr;
        logic [LANES-1:0][ORDER_W-1:0] lane;  // lane 0 in the low bits
    } beat_u;

endpackage

/* hdl/cfg_extract_top.sv */
`timescale 1ns/100ps

module cfg_extract_top (
    input  logic                                axis_clk,
    input  logic                                aresetn,

    // incoming control stream
    input  logic [cfg_extract_pkg::DATA_W-1:0]  i_ctrl_tdata,
    input  logic [cfg_extract_pkg::KEEP_W-1:0]  i_ctrl_tkeep,
    input  logic                                i_ctrl_tvalid,
    input  logic                                i_ctrl_tlast,

    // forwarded foreign packets
    output logic [cfg_extract_pkg::DATA_W-1:0]  o_ctrl_tdata,
    output logic [cfg_extract_pkg::KEEP_W-1:0]  o_ctrl_tkeep,
    output logic                                o_ctrl_tvalid,
    output logic                                o_ctrl_tlast,

    // published configuration table
    output logic [cfg_extract_pkg::CFG_W-1:0]   o_cfg_info,
    output logic                                o_cfg_update
);

    logic                                   seg_wr;
    logic [cfg_extract_pkg::SEG_IDX_W-1:0]  seg_sel;
    logic                                   commit;
    logic                                   pass;   // stage 1 beat is foreign

    ////////////////////////////////////////
    // packet classification
    ////////////////////////////////////////
    cfg_rx_fsm u_rx_fsm (
        .axis_clk  (axis_clk),
        .aresetn   (aresetn),
        .i_tdata   (i_ctrl_tdata),
        .i_tvalid  (i_ctrl_tvalid),
        .i_tlast   (i_ctrl_tlast),
        .o_seg_wr  (seg_wr),
        .o_seg_sel (seg_sel),
        .o_commit  (commit),
        .o_pass    (pass)
    );

    ////////////////////////////////////////
    // table loading
    ////////////////////////////////////////
    cfg_table_store u_table_store (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .i_tdata      (i_ctrl_tdata),
        .i_seg_wr     (seg_wr),
        .i_seg_sel    (seg_sel),
        .i_commit     (commit),
        .o_cfg_info   (o_cfg_info),
        .o_cfg_update (o_cfg_update)
    );

    ////////////////////////////////////////
    // foreign packet bypass
    ////////////////////////////////////////
    ctrl_bypass u_bypass (
        .axis_clk (axis_clk),
        .aresetn  (aresetn),
        .i_tdata  (i_ctrl_tdata),
        .i_tkeep  (i_ctrl_tkeep),
        .i_tvalid (i_ctrl_tvalid),
        .i_tlast  (i_ctrl_tlast),
        .i_pass   (pass),
        .o_tdata  (o_ctrl_tdata),
        .o_tkeep  (o_ctrl_tkeep),
        .o_tvalid (o_ctrl_tvalid),
        .o_tlast  (o_ctrl_tlast)
    );

endmodule

/* hdl/cfg_rx_fsm.sv */
`timescale 1ns/100ps

module cfg_rx_fsm (
    input  logic                                    axis_clk,
    input  logic                                    aresetn,
    input  cfg_extract_pkg::beat_u                  i_tdata,
    input  logic                                    i_tvalid,
    input  logic                                    i_tlast,
    output logic                                    o_seg_wr,
    output logic [cfg_extract_pkg::SEG_IDX_W-1:0]   o_seg_sel,
    output logic                                    o_commit,
    output logic                                    o_pass
);

    logic [cfg_extract_pkg::STATE_W-1:0]    state;
    logic [cfg_extract_pkg::STATE_W-1:0]    state_nxt;
    logic [cfg_extract_pkg::SEG_IDX_W-1:0]  seg_cnt;    // next payload segment
    logic                                   first_beat;
    logic                                   id_match;
    logic                                   last_seg;

    // a new packet may start right in the cycle after a forwarded tail
    assign first_beat = i_tvalid && (state == cfg_extract_pkg::ST_HDR1 ||
                                     state == cfg_extract_pkg::ST_FWD_TAIL);
    assign id_match   = (i_tdata.hdr.mod_id == cfg_extract_pkg::CFG_MODULE_ID);
    assign last_seg   = (seg_cnt == cfg_extract_pkg::LAST_SEG);

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            cfg_extract_pkg::ST_HDR1: begin
                if (first_beat)
                    state_nxt = cfg_extract_pkg::ST_HDR2;
            end
            cfg_extract_pkg::ST_HDR2: begin
                if (i_tvalid) begin
                    if (id_match)   // header only packet has nothing to load
                        state_nxt = i_tlast ? cfg_extract_pkg::ST_HDR1 : cfg_extract_pkg::ST_LOAD;
                    else
                        state_nxt = i_tlast ? cfg_extract_pkg::ST_FWD_TAIL
                                            : cfg_extract_pkg::ST_FWD;
                end
            end
            cfg_extract_pkg::ST_LOAD: begin
                if (i_tvalid) begin
                    if (last_seg)   // too long goes to flush
                        state_nxt = i_tlast ? cfg_extract_pkg::ST_HDR1 : cfg_extract_pkg::ST_FLUSH;
                    else if (i_tlast)
                        state_nxt = cfg_extract_pkg::ST_HDR1;   // short packet, abort
                end
            end
            cfg_extract_pkg::ST_FWD: begin
                if (i_tvalid && i_tlast)
                    state_nxt = cfg_extract_pkg::ST_FWD_TAIL;
            end
            cfg_extract_pkg::ST_FWD_TAIL: begin
                state_nxt = first_beat ? cfg_extract_pkg::ST_HDR2 : cfg_extract_pkg::ST_HDR1;
            end
            cfg_extract_pkg::ST_FLUSH: begin
                if (i_tvalid && i_tlast)
                    state_nxt = cfg_extract_pkg::ST_HDR1;
            end
            default: state_nxt = cfg_extract_pkg::ST_HDR1;
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            state   <= cfg_extract_pkg::ST_HDR1;
            seg_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state != cfg_extract_pkg::ST_LOAD)
                seg_cnt <= '0;
            else if (i_tvalid)
                seg_cnt <= seg_cnt + 1'b1;  // wraps as the fsm leaves load
        end
    end

    ////////////////////////////////////////
    // strobes to table store and bypass
    ////////////////////////////////////////
    assign o_seg_wr  = (state == cfg_extract_pkg::ST_LOAD) && i_tvalid;
    assign o_seg_sel = seg_cnt;
    assign o_commit  = o_seg_wr && last_seg && i_tlast;

    // covers beat 1 held in stage 1 up to the last beat held in stage 1
    assign o_pass = (state == cfg_extract_pkg::ST_HDR2 && i_tvalid && !id_match) ||
                    state == cfg_extract_pkg::ST_FWD ||
                    state == cfg_extract_pkg::ST_FWD_TAIL;

    // single beat packets would be taken as a header and break classification
    a_no_single_beat: assert property (@(posedge axis_clk) disable iff (!aresetn)
        first_beat |-> !i_tlast)
        else $error("tlast seen on the first beat of a packet");

endmodule

/* hdl/cfg_table_store.sv */
`timescale 1ns/100ps

module cfg_table_store (
    input  logic                                    axis_clk,
    input  logic                                    aresetn,
    input  cfg_extract_pkg::beat_u                  i_tdata,
    input  logic                                    i_seg_wr,
    input  logic [cfg_extract_pkg::SEG_IDX_W-1:0]   i_seg_sel,
    input  logic                                    i_commit,
    output logic [cfg_extract_pkg::CFG_W-1:0]       o_cfg_info,
    output logic                                    o_cfg_update
);

    logic [cfg_extract_pkg::LANES-1:0][cfg_extract_pkg::ORDER_W-1:0]   swapped;
    logic [cfg_extract_pkg::NUM_SEG-1:0][cfg_extract_pkg::DATA_W-1:0]  shadow;
    logic [cfg_extract_pkg::NUM_SEG-1:0][cfg_extract_pkg::DATA_W-1:0]  table_nxt;

    ////////////////////////////////////////
    // byte pair swap per 16-bit lane
    ////////////////////////////////////////
    always_comb begin
        for (int k = 0; k < cfg_extract_pkg::LANES; k++) begin
            swapped[k] = {i_tdata.lane[k][cfg_extract_pkg::ORDER_W/2-1:0],
                          i_tdata.lane[k][cfg_extract_pkg::ORDER_W-1:cfg_extract_pkg::ORDER_W/2]};
        end
    end

    // shadow segments, only published on commit
    always_ff @(posedge axis_clk) begin
        if (i_seg_wr)
            shadow[i_seg_sel] <= swapped;
    end

    // last segment is taken straight from the bus in the commit cycle
    always_comb begin
        table_nxt = shadow;
        if (i_seg_wr)
            table_nxt[i_seg_sel] = swapped;
    end

    ////////////////////////////////////////
    // published table
    ////////////////////////////////////////
    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            o_cfg_info   <= '0;
            o_cfg_update <= 1'b0;
        end else begin
            o_cfg_update <= i_commit;   // one cycle after the final beat
            if (i_commit)
                o_cfg_info <= table_nxt;
        end
    end

    // the bypass of the shadow only fills the last segment when commit comes with its write
    a_commit_last_seg: assert property (@(posedge axis_clk) disable iff (!aresetn)
        i_commit |-> (i_seg_wr && i_seg_sel == cfg_extract_pkg::LAST_SEG))
        else $error("commit without a write of the last segment");

    // a config packet needs a header plus NUM_SEG beats, so updates cannot be adjacent
    a_update_pulse: assert property (@(posedge axis_clk) disable iff (!aresetn)
        o_cfg_update |=> !o_cfg_update)
        else $error("cfg update held for two cycles");

endmodule

/* hdl/ctrl_bypass.sv */
`timescale 1ns/100ps

module ctrl_bypass (
    input  logic                                axis_clk,
    input  logic                                aresetn,
    input  logic [cfg_extract_pkg::DATA_W-1:0]  i_tdata,
    input  logic [cfg_extract_pkg::KEEP_W-1:0]  i_tkeep,
    input  logic                                i_tvalid,
    input  logic                                i_tlast,
    input  logic                                i_pass,
    output logic [cfg_extract_pkg::DATA_W-1:0]  o_tdata,
    output logic [cfg_extract_pkg::KEEP_W-1:0]  o_tkeep,
    output logic                                o_tvalid,
    output logic                                o_tlast
);

    logic [cfg_extract_pkg::DATA_W-1:0] s1_data;
    logic [cfg_extract_pkg::KEEP_W-1:0] s1_keep;
    logic                               s1_valid;
    logic                               s1_last;

    ////////////////////////////////////////
    // stage 1, holds beat 1 until the id is seen
    ////////////////////////////////////////
    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= i_tvalid;   // gaps pass through as bubbles
            s1_last  <= i_tlast;
        end
    end

    always_ff @(posedge axis_clk) begin
        s1_data <= i_tdata;
        s1_keep <= i_tkeep;
    end

    ////////////////////////////////////////
    // stage 2, drops config beats
    ////////////////////////////////////////
    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            o_tvalid <= 1'b0;
            o_tlast  <= 1'b0;
        end else begin
            o_tvalid <= i_pass && s1_valid;
            o_tlast  <= i_pass && s1_last;
        end
    end

    always_ff @(posedge axis_clk) begin
        o_tdata <= i_pass ? s1_data : '0;   // cleared so config payload never leaks
        o_tkeep <= i_pass ? s1_keep : '0;
    end

    // pass first rises while beat 1 of the foreign packet sits in stage 1
    a_pass_on_beat1: assert property (@(posedge axis_clk) disable iff (!aresetn)
        $rose(i_pass) |-> s1_valid)
        else $error("pass raised with no beat held in stage 1");

endmodule

/* project.f */
hdl/cfg_extract_pkg.sv
hdl/cfg_rx_fsm.sv
hdl/cfg_table_store.sv
hdl/ctrl_bypass.sv
hdl/cfg_extract_top.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cfg_extract testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f project.f -o tb_sim > "$BUILD_LOG" 2>&1 \
    || { echo "build failed, see $BUILD_LOG"; exit 1; }

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

# a run that stops early prints no result line and counts as a failure
grep -q "TB FAILED" "$SIM_LOG" && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" "$SIM_LOG" && { echo "simulation passed"; exit 0; }
echo "simulation ended without a result"
exit 1

/* verif/tb_checker.sv */
`timescale 1ns/100ps

module tb_checker (
    input  logic                                axis_clk,
    input  logic                                aresetn,
    input  logic [cfg_extract_pkg::DATA_W-1:0]  i_in_tdata,
    input  logic [cfg_extract_pkg::KEEP_W-1:0]  i_in_tkeep,
    input  logic                                i_in_tvalid,
    input  logic                                i_in_tlast,
    input  logic [cfg_extract_pkg::DATA_W-1:0]  i_out_tdata,
    input  logic [cfg_extract_pkg::KEEP_W-1:0]  i_out_tkeep,
    input  logic                                i_out_tvalid,
    input  logic                                i_out_tlast,
    input  logic [cfg_extract_pkg::CFG_W-1:0]   i_cfg_info,
    input  logic                                i_cfg_update,
    output int                                  o_pending,
    output int                                  o_fwd_errors,
    output int                                  o_upd_errors
);

    string                              test_name = "none";
    int                                 cycle = 0;
    int                                 beat_no = 0;    // beats seen in the current packet
    logic                               is_cfg = 1'b0;
    int                                 pay_cnt = 0;
    logic [cfg_extract_pkg::CFG_W-1:0]  pay_buf;
    logic [cfg_extract_pkg::DATA_W-1:0] hdr1_data;
    logic [cfg_extract_pkg::KEEP_W-1:0] hdr1_keep;
    int                                 hdr1_cycle;

    // expected forwarded beats, oldest first
    int                                 due_q[$];
    logic [cfg_extract_pkg::DATA_W-1:0] data_q[$];
    logic [cfg_extract_pkg::KEEP_W-1:0] keep_q[$];
    logic                               last_q[$];

    int                                 upd_due = -1;   // no update pending
    logic [cfg_extract_pkg::CFG_W-1:0]  upd_table;
    logic [cfg_extract_pkg::CFG_W-1:0]  model_table = '0;

    initial begin
        o_pending    = 0;
        o_fwd_errors = 0;
        o_upd_errors = 0;
    end

    ////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////
    function automatic logic is_config(input logic [cfg_extract_pkg::DATA_W-1:0] hdr2);
        return hdr2[cfg_extract_pkg::MOD_ID_LSB +: cfg_extract_pkg::MOD_ID_W] ==
               cfg_extract_pkg::CFG_MODULE_ID;
    endfunction

    // order 16*s+k is lane k of payload beat s with its two bytes exchanged
    function automatic logic [cfg_extract_pkg::CFG_W-1:0] swap_table(
        input logic [cfg_extract_pkg::CFG_W-1:0] pay);
        logic [cfg_extract_pkg::CFG_W-1:0] t;
        int i;
        for (i = 0; i < cfg_extract_pkg::CFG_W / 16; i++)
            t[i*16 +: 16] = {pay[i*16 +: 8], pay[i*16+8 +: 8]};
        return t;
    endfunction

    task automatic push_fwd(input int due, input logic [cfg_extract_pkg::DATA_W-1:0] d,
                            input logic [cfg_extract_pkg::KEEP_W-1:0] k, input logic l);
        due_q.push_back(due);
        data_q.push_back(d);
        keep_q.push_back(k);
        last_q.push_back(l);
    endtask

    ////////////////////////////////////////
    // comparisons
    ////////////////////////////////////////
    task automatic check_forward();
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            if (i_out_tvalid !== 1'b1) begin
                $display("Error %s: o_ctrl_tvalid expected 1 actual %b", test_name, i_out_tvalid);
                o_fwd_errors++;
            end else begin
                if (i_out_tdata !== data_q[0]) begin
                    $display("Error %s: o_ctrl_tdata expected %h actual %h",
                             test_name, data_q[0], i_out_tdata);
                    o_fwd_errors++;
                end
                if (i_out_tkeep !== keep_q[0] || i_out_tlast !== last_q[0]) begin
                    $display("Error %s: keep/last expected %h/%b actual %h/%b", test_name,
                             keep_q[0], last_q[0], i_out_tkeep, i_out_tlast);
                    o_fwd_errors++;
                end
            end
            void'(due_q.pop_front());
            void'(data_q.pop_front());
            void'(keep_q.pop_front());
            void'(last_q.pop_front());
        end else if (i_out_tvalid !== 1'b0 || i_out_tlast !== 1'b0) begin
            $display("Error %s: o_ctrl_tvalid/tlast expected 0/0 actual %b/%b",
                     test_name, i_out_tvalid, i_out_tlast);
            o_fwd_errors++;
        end
    endtask

    task automatic check_update();
        if (upd_due == cycle) begin
            model_table = upd_table;    // new table visible with the pulse
            upd_due     = -1;
            if (i_cfg_update !== 1'b1) begin
                $display("Error %s: o_cfg_update expected 1 actual %b", test_name, i_cfg_update);
                o_upd_errors++;
            end
        end else if (i_cfg_update !== 1'b0) begin
            $display("Error %s: o_cfg_update expected 0 actual %b", test_name, i_cfg_update);
            o_upd_errors++;
        end
        if (i_cfg_info !== model_table) begin
            $display("Error %s: o_cfg_info expected %h actual %h",
                     test_name, model_table, i_cfg_info);
            o_upd_errors++;
        end
    endtask

    // classify packets from the input side and queue what should come out
    task automatic track_input();
        if (i_in_tvalid) begin
            beat_no++;
            if (beat_no == 1) begin
                hdr1_data  = i_in_tdata;
                hdr1_keep  = i_in_tkeep;
                hdr1_cycle = cycle;
            end else if (beat_no == 2) begin
                is_cfg  = is_config(i_in_tdata);
                pay_cnt = 0;
                if (!is_cfg) begin
                    push_fwd(hdr1_cycle + 2, hdr1_data, hdr1_keep, 1'b0);
                    push_fwd(cycle + 2, i_in_tdata, i_in_tkeep, i_in_tlast);
                end
            end else if (is_cfg) begin
                if (pay_cnt < cfg_extract_pkg::NUM_SEG)
                    pay_buf[pay_cnt*cfg_extract_pkg::DATA_W +: cfg_extract_pkg::DATA_W] =
                        i_in_tdata;
                pay_cnt++;
            end else begin
                push_fwd(cycle + 2, i_in_tdata, i_in_tkeep, i_in_tlast);
            end
            if (i_in_tlast) begin
                if (is_cfg && beat_no > 2 && pay_cnt == cfg_extract_pkg::NUM_SEG) begin
                    upd_due   = cycle + 1;
                    upd_table = swap_table(pay_buf);
                end
                beat_no = 0;
            end
        end
    endtask

    // inputs and registered outputs are both settled at the falling edge
    always @(negedge axis_clk) begin
        if (aresetn) begin
            cycle++;
            check_forward();
            check_update();
            track_input();
            o_pending = due_q.size() + ((upd_due >= 0) ? 1 : 0);
        end
    end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;     // 20 ns period
    end

    // reset held for 5 cycles, released just after an edge
    initial begin
        o_rst_n = 1'b0;
        repeat (5) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/100ps

module tb_top;

    logic                               axis_clk;
    logic                               aresetn;
    logic [cfg_extract_pkg::DATA_W-1:0] in_tdata;
    logic [cfg_extract_pkg::KEEP_W-1:0] in_tkeep;
    logic                               in_tvalid;
    logic                               in_tlast;
    logic [cfg_extract_pkg::DATA_W-1:0] out_tdata;
    logic [cfg_extract_pkg::KEEP_W-1:0] out_tkeep;
    logic                               out_tvalid;
    logic                               out_tlast;
    logic [cfg_extract_pkg::CFG_W-1:0]  cfg_info;
    logic                               cfg_update;
    int                                 pending;
    int                                 fwd_errors;
    int                                 upd_errors;
    int                                 timeout_errors = 0;
    int                                 seed = 77222;

    tb_clock_gen u_clock_gen (.o_clk(axis_clk), .o_rst_n(aresetn));

    cfg_extract_top DUT (
        .axis_clk      (axis_clk),
        .aresetn       (aresetn),
        .i_ctrl_tdata  (in_tdata),
        .i_ctrl_tkeep  (in_tkeep),
        .i_ctrl_tvalid (in_tvalid),
        .i_ctrl_tlast  (in_tlast),
        .o_ctrl_tdata  (out_tdata),
        .o_ctrl_tkeep  (out_tkeep),
        .o_ctrl_tvalid (out_tvalid),
        .o_ctrl_tlast  (out_tlast),
        .o_cfg_info    (cfg_info),
        .o_cfg_update  (cfg_update)
    );

    tb_checker u_checker (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .i_in_tdata   (in_tdata),
        .i_in_tkeep   (in_tkeep),
        .i_in_tvalid  (in_tvalid),
        .i_in_tlast   (in_tlast),
        .i_out_tdata  (out_tdata),
        .i_out_tkeep  (out_tkeep),
        .i_out_tvalid (out_tvalid),
        .i_out_tlast  (out_tlast),
        .i_cfg_info   (cfg_info),
        .i_cfg_update (cfg_update),
        .o_pending    (pending),
        .o_fwd_errors (fwd_errors),
        .o_upd_errors (upd_errors)
    );

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    function automatic logic [cfg_extract_pkg::DATA_W-1:0] rand_beat();
        logic [cfg_extract_pkg::DATA_W-1:0] b;
        int i;
        for (i = 0; i < cfg_extract_pkg::DATA_W / 32; i++)
            b[i*32 +: 32] = $random(seed);
        return b;
    endfunction

    task automatic drive_beat(input logic [cfg_extract_pkg::DATA_W-1:0] d,
                              input logic [cfg_extract_pkg::KEEP_W-1:0] k, input logic l);
        @(posedge axis_clk);
        #1;
        in_tvalid = 1'b1;
        in_tdata  = d;
        in_tkeep  = k;
        in_tlast  = l;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge axis_clk);
            #1;
            in_tvalid = 1'b0;
            in_tlast  = 1'b0;
            in_tdata  = rand_beat();    // junk on the bus while idle
        end
    endtask

    // header beats go back to back, gaps only after beat 2
    task automatic send_packet(input logic cfg, input int n_beats);
        logic [cfg_extract_pkg::DATA_W-1:0] d;
        int b;
        for (b = 1; b <= n_beats; b++) begin
            d = rand_beat();
            if (b == 2)
                d[cfg_extract_pkg::MOD_ID_LSB +: cfg_extract_pkg::MOD_ID_W] =
                    cfg ? cfg_extract_pkg::CFG_MODULE_ID : 4'({$random(seed)} % 15);
            drive_beat(d, $random(seed), b == n_beats);
            if (b >= 2 && b < n_beats && ({$random(seed)} % 4) == 0)
                idle_cycles(1 + {$random(seed)} % 3);
        end
    endtask

    task automatic start_test(input string name);
        u_checker.test_name = name;
        $display("running %s", name);
    endtask

    task automatic wait_for_update(input int max_cycles);
        int n;
        n = 0;
        idle_cycles(1);
        while (!cfg_update && n < max_cycles) begin
            @(posedge axis_clk);
            #1;
            n++;
        end
        if (!cfg_update) begin
            $display("Timeout: no table update seen within %0d cycles", max_cycles);
            timeout_errors++;
        end
    endtask

    task automatic drain(input int max_cycles);
        int n;
        n = 0;
        idle_cycles(1);
        while (pending != 0 && n < max_cycles) begin
            @(posedge axis_clk);
            #1;
            n++;
        end
        if (pending != 0) begin
            $display("Timeout: %0d expected events still missing after %0d cycles",
                     pending, max_cycles);
            timeout_errors++;
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        int n;
        int p;
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
        in_tdata  = '0;
        in_tkeep  = '0;

        start_test("reset_state");
        n = 0;
        while (aresetn !== 1'b1 && n < 50) begin
            @(posedge axis_clk);
            n++;
        end
        if (aresetn !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeout_errors++;
        end
        idle_cycles(4);

        start_test("cfg_good");
        send_packet(1'b1, 2 + cfg_extract_pkg::NUM_SEG);
        wait_for_update(20);

        start_test("foreign");
        send_packet(1'b0, 2 + {$random(seed)} % 7);
        drain(50);

        start_test("cfg_short");
        send_packet(1'b1, 4);   // tlast on payload beat 2
        send_packet(1'b1, 2 + cfg_extract_pkg::NUM_SEG);
        wait_for_update(20);

        start_test("cfg_long");
        send_packet(1'b1, 8);   // 6 payload beats, flushed
        send_packet(1'b0, 2 + {$random(seed)} % 7);
        drain(50);

        start_test("mixed");
        for (p = 0; p < 20; p++) begin
            if (({$random(seed)} % 2) == 0) begin
                n = (({$random(seed)} % 2) == 0) ? 4 : 2 + {$random(seed)} % 5;
                send_packet(1'b1, n + 2);
            end else begin
                send_packet(1'b0, 2 + {$random(seed)} % 7);
            end
            idle_cycles({$random(seed)} % 3);
        end
        drain(100);
        idle_cycles(3);

        $display("errors: forward %0d, update %0d, timeout %0d",
                 fwd_errors, upd_errors, timeout_errors);
        if (fwd_errors + upd_errors + timeout_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
